// ==== design/audio_settings.svh ====
// --------------------------------------------------------------------------
// Shared widths and rates for the console audio output path.
// Included by the package, the RTL and the testbench.
// --------------------------------------------------------------------------

`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// PCM sample width from the console core
`define AUDIO_PCM_BITS 16

// Width of each analog DAC output
`define AUDIO_DAC_BITS 4

// Zero bits below the sample in the transmitter word (16 + 8 = 24)
`define AUDIO_WORD_PAD 8

// clk_2x cycles per transmitter word, short for simulation
// A board build sets this from the clk_2x rate and the sample rate
`define AUDIO_WORD_DIVISOR 16

`endif

// ==== design/audio_pkg.sv ====
// --------------------------------------------------------------------------
// Sample types for the audio output path and the conversion from the
// core's signed PCM into the offset binary used by the DACs and the feed.
// --------------------------------------------------------------------------

`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

    // Signed two's complement sample, as delivered by the core
    typedef logic signed [`AUDIO_PCM_BITS-1:0] pcm_t;

    // Unsigned offset binary, zero maps to mid-scale
    typedef logic [`AUDIO_PCM_BITS-1:0] pcm_ofs_t;

    // Flipping the sign bit shifts the range up by half scale
    function automatic pcm_ofs_t to_offset_binary(input pcm_t sample);
        pcm_ofs_t result;
        result = pcm_ofs_t'(sample);
        result[`AUDIO_PCM_BITS-1] = ~sample[`AUDIO_PCM_BITS-1];
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== design/audio_sample_hold.sv ====
// --------------------------------------------------------------------------
// Holding register for the stereo pair from the console core. A pair is
// taken only on the valid strobe, converted to offset binary and kept for
// the DAC and transmitter stages until the next strobe replaces it.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module audio_sample_hold
    import audio_pkg::*;
(
    input  logic     clk_2x,
    input  logic     arst_n,

    // Pair from the core, meaningful only with the strobe
    input  pcm_t     audio_output_l,
    input  pcm_t     audio_output_r,
    input  logic     audio_output_valid,

    // Latest pair in offset binary
    output pcm_ofs_t held_l,
    output pcm_ofs_t held_r,
    output logic     held_update
);

    // Signed zero in offset binary
    localparam pcm_ofs_t MID_SCALE = to_offset_binary(pcm_t'(0));

    pcm_ofs_t next_l;
    pcm_ofs_t next_r;

    assign next_l = to_offset_binary(audio_output_l);
    assign next_r = to_offset_binary(audio_output_r);

    // Pair register, loaded only on the strobe
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            held_l <= MID_SCALE;
            held_r <= MID_SCALE;
        end else if (audio_output_valid) begin
            held_l <= next_l;
            held_r <= next_r;
        end
    end

    // Pulses in the same cycle the new pair shows on held_l/held_r
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            held_update <= 1'b0;
        end else begin
            held_update <= audio_output_valid;
        end
    end

endmodule

`default_nettype wire

// ==== design/audio_dac_pwm.sv ====
// --------------------------------------------------------------------------
// Single channel of a dithered PWM DAC. The top bits of the held sample
// give the coarse level and the remaining bits are spread over time by a
// first-order accumulator, so the average output tracks the full sample.
// Instantiated once per channel.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module audio_dac_pwm
    import audio_pkg::*;
(
    input  logic                       clk_2x,
    input  logic                       arst_n,

    // Held sample in offset binary
    input  pcm_ofs_t                   pcm,

    // Level for the resistor ladder
    output logic [`AUDIO_DAC_BITS-1:0] dac
);

    // Bits below the coarse level, 12 with the default widths
    localparam int FINE_BITS = `AUDIO_PCM_BITS - `AUDIO_DAC_BITS;

    localparam logic [`AUDIO_DAC_BITS-1:0] DAC_MID =
        {1'b1, {(`AUDIO_DAC_BITS-1){1'b0}}};
    localparam logic [`AUDIO_DAC_BITS-1:0] DAC_MAX = '1;

    logic [`AUDIO_DAC_BITS-1:0] coarse;
    logic [FINE_BITS-1:0]       fine;
    logic [FINE_BITS-1:0]       acc;
    logic [FINE_BITS:0]         acc_sum;
    logic                       carry;
    logic [`AUDIO_DAC_BITS-1:0] level;

    // Split the sample into the ladder step and the dither fraction
    assign coarse = pcm[`AUDIO_PCM_BITS-1 -: `AUDIO_DAC_BITS];
    assign fine   = pcm[FINE_BITS-1:0];

    // One carry per wrap, so the fraction sets the duty of the extra step
    assign acc_sum = {1'b0, acc} + {1'b0, fine};
    assign carry   = acc_sum[FINE_BITS];

    // Top step has no step above it, the carry is lost there
    always_comb begin
        if (carry && (coarse != DAC_MAX)) begin
            level = coarse + 1'b1;
        end else begin
            level = coarse;
        end
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
            dac <= DAC_MID;
        end else begin
            acc <= acc_sum[FINE_BITS-1:0];
            dac <= level;
        end
    end

endmodule

`default_nettype wire

// ==== design/audio_word_select.sv ====
// --------------------------------------------------------------------------
// Word feed for a digital audio transmitter. A fixed-rate tick alternates
// the channel, and each new word carries that channel's held sample with
// zero padding below it. The strobe marks each word, the consumer has no
// way to stall it.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module audio_word_select
    import audio_pkg::*;
(
    input  logic                                         clk_2x,
    input  logic                                         arst_n,

    // Held pair in offset binary
    input  pcm_ofs_t                                     held_l,
    input  pcm_ofs_t                                     held_r,

    // Transmitter side
    output logic [`AUDIO_PCM_BITS+`AUDIO_WORD_PAD-1:0]   spdif_word,
    output logic                                         spdif_channel,
    output logic                                         spdif_strobe
);

    localparam int PAD_W = `AUDIO_WORD_PAD;
    localparam int CNT_W = ($clog2(`AUDIO_WORD_DIVISOR) > 0) ?
                           $clog2(`AUDIO_WORD_DIVISOR) : 1;
    localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(`AUDIO_WORD_DIVISOR - 1);

    logic [CNT_W-1:0] tick_cnt;
    logic             tick;
    logic             next_channel;
    pcm_ofs_t         next_sample;

    assign tick = (tick_cnt == '0);

    // Channel 1 after reset, so the first word is left
    assign next_channel = ~spdif_channel;
    assign next_sample  = next_channel ? held_r : held_l;

    // Word rate divider, one tick every AUDIO_WORD_DIVISOR cycles
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= CNT_RELOAD;
        end else if (tick) begin
            tick_cnt <= CNT_RELOAD;
        end else begin
            tick_cnt <= tick_cnt - 1'b1;
        end
    end

    // Word, flag and strobe all land in the cycle after the tick
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            spdif_strobe  <= 1'b0;
            spdif_channel <= 1'b1;
            spdif_word    <= '0;
        end else begin
            spdif_strobe <= tick;
            if (tick) begin
                spdif_channel <= next_channel;
                spdif_word    <= {next_sample, {PAD_W{1'b0}}};
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/audio_out_top.sv ====
// --------------------------------------------------------------------------
// Audio output path of the console board. Holds the pair from the core,
// drives the two analog DAC ladders and feeds the digital transmitter
// words. Everything runs on clk_2x.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module audio_out_top
    import audio_pkg::*;
(
    input  logic                                       clk_2x,
    input  logic                                       arst_n,

    // From the console core
    input  logic [`AUDIO_PCM_BITS-1:0]                 audio_output_l,
    input  logic [`AUDIO_PCM_BITS-1:0]                 audio_output_r,
    input  logic                                       audio_output_valid,

    // Analog ladders
    output logic [`AUDIO_DAC_BITS-1:0]                 audio_l,
    output logic [`AUDIO_DAC_BITS-1:0]                 audio_r,

    // Digital transmitter feed
    output logic [`AUDIO_PCM_BITS+`AUDIO_WORD_PAD-1:0] spdif_word,
    output logic                                       spdif_channel,
    output logic                                       spdif_strobe
);

    pcm_ofs_t held_l;
    pcm_ofs_t held_r;

    // New-pair pulse, observed by the bound checker and in waveforms
    logic     held_update;

    audio_sample_hold hold_i (
        .clk_2x             (clk_2x),
        .arst_n             (arst_n),
        .audio_output_l     (audio_output_l),
        .audio_output_r     (audio_output_r),
        .audio_output_valid (audio_output_valid),
        .held_l             (held_l),
        .held_r             (held_r),
        .held_update        (held_update)
    );

    audio_dac_pwm dac_l_i (
        .clk_2x (clk_2x),
        .arst_n (arst_n),
        .pcm    (held_l),
        .dac    (audio_l)
    );

    audio_dac_pwm dac_r_i (
        .clk_2x (clk_2x),
        .arst_n (arst_n),
        .pcm    (held_r),
        .dac    (audio_r)
    );

    audio_word_select word_i (
        .clk_2x        (clk_2x),
        .arst_n        (arst_n),
        .held_l        (held_l),
        .held_r        (held_r),
        .spdif_word    (spdif_word),
        .spdif_channel (spdif_channel),
        .spdif_strobe  (spdif_strobe)
    );

endmodule

`default_nettype wire

// ==== tests/audio_out_chk.sv ====
// --------------------------------------------------------------------------
// Concurrent assertions on the audio output top level, bound to it from
// the testbench. Covers strobe spacing, channel flag, DAC reset level and
// the new-pair pulse of the hold stage.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "audio_settings.svh"
`default_nettype none

module audio_out_chk (
    input  logic                       clk_2x,
    input  logic                       arst_n,
    input  logic                       audio_output_valid,
    input  logic                       held_update,
    input  logic [`AUDIO_DAC_BITS-1:0] audio_l,
    input  logic [`AUDIO_DAC_BITS-1:0] audio_r,
    input  logic                       spdif_channel,
    input  logic                       spdif_strobe
);

    int fail_count;

    initial fail_count = 0;

    // Strobe is a single-cycle pulse
    strobe_single: assert property (@(posedge clk_2x) disable iff (!arst_n)
        spdif_strobe |=> !spdif_strobe)
        else begin
            fail_count++;
            $error("spdif_strobe high in two consecutive cycles");
        end

    // Flag only moves together with a new word
    channel_on_strobe: assert property (@(posedge clk_2x) disable iff (!arst_n)
        !$stable(spdif_channel) |-> spdif_strobe)
        else begin
            fail_count++;
            $error("spdif_channel changed without spdif_strobe");
        end

    // New pair lands one cycle after the core strobe
    update_after_valid: assert property (@(posedge clk_2x) disable iff (!arst_n)
        held_update == $past(audio_output_valid))
        else begin
            fail_count++;
            $error("held_update does not follow audio_output_valid by one cycle");
        end

    // Ladders sit at mid-scale while in reset
    dac_mid_in_reset: assert property (@(posedge clk_2x)
        !arst_n |-> (audio_l == 4'd8 && audio_r == 4'd8))
        else begin
            fail_count++;
            $error("DAC outputs not at mid-scale during reset");
        end

endmodule

`default_nettype wire

// ==== tests/audio_out_scoreboard.sv ====
// --------------------------------------------------------------------------
// Reference model and comparator for the audio output path. Tracks the
// hold register, both DAC accumulators and the word tick, compares every
// cycle and keeps the per-test pass and fail counts for the testbench.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "audio_settings.svh"
`default_nettype none

module audio_out_scoreboard (
    input  logic                                       clk_2x,
    input  logic                                       arst_n,
    input  logic [`AUDIO_PCM_BITS-1:0]                 audio_output_l,
    input  logic [`AUDIO_PCM_BITS-1:0]                 audio_output_r,
    input  logic                                       audio_output_valid,
    input  logic [`AUDIO_DAC_BITS-1:0]                 audio_l,
    input  logic [`AUDIO_DAC_BITS-1:0]                 audio_r,
    input  logic [`AUDIO_PCM_BITS+`AUDIO_WORD_PAD-1:0] spdif_word,
    input  logic                                       spdif_channel,
    input  logic                                       spdif_strobe
);

    localparam int PCM_W  = `AUDIO_PCM_BITS;
    localparam int DAC_W  = `AUDIO_DAC_BITS;
    localparam int FINE_W = PCM_W - DAC_W;
    localparam int WORD_W = `AUDIO_PCM_BITS + `AUDIO_WORD_PAD;
    localparam int DIV    = `AUDIO_WORD_DIVISOR;

    logic [PCM_W-1:0]  m_held_l;
    logic [PCM_W-1:0]  m_held_r;
    logic [FINE_W-1:0] m_acc_l;
    logic [FINE_W-1:0] m_acc_r;
    logic [DAC_W-1:0]  m_dac_l;
    logic [DAC_W-1:0]  m_dac_r;
    logic [WORD_W-1:0] m_word;
    logic              m_chan;
    logic              m_strobe;
    int                m_cnt;

    int    errors = 0;
    int    base_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    string test_name;
    int    gap;
    bit    seen_strobe;
    logic  last_chan;

    // Signed to offset binary, top bit inverted
    function automatic logic [PCM_W-1:0] offset(input logic [PCM_W-1:0] s);
        return {~s[PCM_W-1], s[PCM_W-2:0]};
    endfunction

    // Coarse step plus one on accumulator wrap, held at the top step
    function automatic logic [DAC_W-1:0] dac_level(input logic [PCM_W-1:0] w,
                                                   input logic [FINE_W-1:0] acc);
        logic [DAC_W-1:0] coarse;
        bit               wrap;
        coarse = w[PCM_W-1 -: DAC_W];
        wrap   = (int'(acc) + int'(w[FINE_W-1:0])) >= (1 << FINE_W);
        if (wrap && coarse != '1) begin
            return coarse + 1'b1;
        end
        return coarse;
    endfunction

    function automatic void compare(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endfunction

    always @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            m_held_l <= offset('0);
            m_held_r <= offset('0);
            m_acc_l  <= '0;
            m_acc_r  <= '0;
            m_dac_l  <= 4'd8;
            m_dac_r  <= 4'd8;
            m_cnt    <= DIV - 1;
            m_strobe <= 1'b0;
            m_chan   <= 1'b1;
            m_word   <= '0;
        end else begin
            if (audio_output_valid) begin
                m_held_l <= offset(audio_output_l);
                m_held_r <= offset(audio_output_r);
            end
            m_acc_l  <= m_acc_l + m_held_l[FINE_W-1:0];
            m_acc_r  <= m_acc_r + m_held_r[FINE_W-1:0];
            m_dac_l  <= dac_level(m_held_l, m_acc_l);
            m_dac_r  <= dac_level(m_held_r, m_acc_r);
            m_strobe <= (m_cnt == 0);
            m_cnt    <= (m_cnt == 0) ? DIV - 1 : m_cnt - 1;
            if (m_cnt == 0) begin
                // New channel is the other one, sample shifted above the pad
                m_chan <= ~m_chan;
                m_word <= WORD_W'(m_chan ? m_held_l : m_held_r) << `AUDIO_WORD_PAD;
            end
        end
    end

    // Outputs are compared away from the active edge
    always @(negedge clk_2x) begin
        if (!arst_n) begin
            gap         = 0;
            seen_strobe = 1'b0;
        end else begin
            compare("audio_l", 32'(audio_l), 32'(m_dac_l));
            compare("audio_r", 32'(audio_r), 32'(m_dac_r));
            compare("spdif_strobe", 32'(spdif_strobe), 32'(m_strobe));
            compare("spdif_channel", 32'(spdif_channel), 32'(m_chan));
            compare("spdif_word", 32'(spdif_word), 32'(m_word));
            if (spdif_strobe) begin
                if (seen_strobe) begin
                    compare("strobe spacing", 32'(gap), 32'(DIV));
                    if (spdif_channel === last_chan) begin
                        errors++;
                        $display("Channel flag did not alternate at %0t", $time);
                    end
                end else begin
                    compare("first spdif_channel", 32'(spdif_channel), 32'h0);
                end
                seen_strobe = 1'b1;
                last_chan   = spdif_channel;
                gap         = 1;
            end else begin
                gap++;
            end
        end
    end

    function automatic void check_reset_state();
        compare("audio_l", 32'(audio_l), 32'h8);
        compare("audio_r", 32'(audio_r), 32'h8);
        compare("spdif_strobe", 32'(spdif_strobe), 32'h0);
    endfunction

    // Sum of one full accumulator period of outputs per channel
    task automatic window_sums(input int exp_l, input int exp_r);
        int sum_l;
        int sum_r;
        sum_l = 0;
        sum_r = 0;
        repeat (1 << FINE_W) begin
            @(negedge clk_2x);
            sum_l += int'(audio_l);
            sum_r += int'(audio_r);
        end
        compare("audio_l window sum", 32'(sum_l), 32'(exp_l));
        compare("audio_r window sum", 32'(sum_r), 32'(exp_r));
    endtask

    function automatic void begin_test(input string name);
        test_name   = name;
        base_errors = errors;
    endfunction

    function automatic void finish_test();
        if (errors == base_errors) begin
            tests_passed++;
            $display("Pass %s", test_name);
        end else begin
            tests_failed++;
            $display("Fail %s: %0d mismatches", test_name, errors - base_errors);
        end
    endfunction

endmodule

`default_nettype wire

// ==== tests/audio_out_tb.sv ====
// --------------------------------------------------------------------------
// Testbench top for the audio output path. Generates clock and reset,
// drives seeded random pairs, runs the tests in sequence and prints the
// result. Comparing is done by the scoreboard and the bound checker.
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`include "audio_settings.svh"
`default_nettype none

module audio_out_tb;

    localparam int PCM_W          = `AUDIO_PCM_BITS;
    localparam int DAC_W          = `AUDIO_DAC_BITS;
    localparam int FINE_W         = PCM_W - DAC_W;
    localparam int STROBE_TIMEOUT = 4 * `AUDIO_WORD_DIVISOR;
    localparam int RANDOM_CYCLES  = 400;

    logic                                       clk_2x;
    logic                                       arst_n;
    logic [PCM_W-1:0]                           audio_output_l;
    logic [PCM_W-1:0]                           audio_output_r;
    logic                                       audio_output_valid;
    logic [DAC_W-1:0]                           audio_l;
    logic [DAC_W-1:0]                           audio_r;
    logic [`AUDIO_PCM_BITS+`AUDIO_WORD_PAD-1:0] spdif_word;
    logic                                       spdif_channel;
    logic                                       spdif_strobe;
    bit                                         timed_out;
    logic [PCM_W-1:0]                           pair_l;
    logic [PCM_W-1:0]                           pair_r;

    audio_out_top dut_i (
        .clk_2x             (clk_2x),
        .arst_n             (arst_n),
        .audio_output_l     (audio_output_l),
        .audio_output_r     (audio_output_r),
        .audio_output_valid (audio_output_valid),
        .audio_l            (audio_l),
        .audio_r            (audio_r),
        .spdif_word         (spdif_word),
        .spdif_channel      (spdif_channel),
        .spdif_strobe       (spdif_strobe)
    );

    audio_out_scoreboard sb_i (.*);

    bind audio_out_top audio_out_chk chk_i (.*);

    initial begin
        clk_2x = 1'b0;
        forever #20 clk_2x = ~clk_2x;
    end

    // Expected 4096-cycle DAC sum for a signed sample
    function automatic int expected_window(input logic [PCM_W-1:0] sample);
        logic [PCM_W-1:0] ofs;
        ofs = {~sample[PCM_W-1], sample[PCM_W-2:0]};
        if (ofs[PCM_W-1 -: DAC_W] == '1) begin
            return ((1 << DAC_W) - 1) << FINE_W;
        end
        return (int'(ofs[PCM_W-1 -: DAC_W]) << FINE_W) + int'(ofs[FINE_W-1:0]);
    endfunction

    task automatic wait_strobes(input int count);
        int n;
        int waited;
        for (n = 0; n < count && !timed_out; n++) begin
            waited = 0;
            @(negedge clk_2x);
            while (!spdif_strobe && waited < STROBE_TIMEOUT) begin
                @(negedge clk_2x);
                waited++;
            end
            if (!spdif_strobe) begin
                $display("Timeout: no word strobe within %0d cycles", STROBE_TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    // One strobed pair, then two edges until the DACs use it
    task automatic load_pair(input logic [PCM_W-1:0] l, input logic [PCM_W-1:0] r);
        @(posedge clk_2x);
        audio_output_l     <= l;
        audio_output_r     <= r;
        audio_output_valid <= 1'b1;
        @(posedge clk_2x);
        audio_output_valid <= 1'b0;
        @(posedge clk_2x);
    endtask

    initial begin
        audio_output_l     = '0;
        audio_output_r     = '0;
        audio_output_valid = 1'b0;
        arst_n             = 1'b1;
        timed_out          = 1'b0;
        void'($urandom(46));

        #5;
        arst_n = 1'b0;
        sb_i.begin_test("reset_state");
        repeat (10) @(posedge clk_2x);
        arst_n <= 1'b1;
        @(negedge clk_2x);
        sb_i.check_reset_state();
        wait_strobes(1);
        sb_i.finish_test();

        sb_i.begin_test("hold_on_valid");
        repeat (RANDOM_CYCLES) begin
            @(posedge clk_2x);
            audio_output_l     <= PCM_W'($urandom);
            audio_output_r     <= PCM_W'($urandom);
            audio_output_valid <= ($urandom % 5) == 0;
        end
        @(posedge clk_2x);
        audio_output_valid <= 1'b0;
        sb_i.finish_test();

        sb_i.begin_test("channel_alternation");
        wait_strobes(8);
        sb_i.finish_test();

        sb_i.begin_test("dac_average");
        repeat (2) begin
            pair_l = PCM_W'($urandom);
            pair_r = PCM_W'($urandom);
            load_pair(pair_l, pair_r);
            sb_i.window_sums(expected_window(pair_l), expected_window(pair_r));
        end
        sb_i.finish_test();

        // Signed maximum, minimum and zero on both channels
        sb_i.begin_test("dac_extremes");
        load_pair(16'h7fff, 16'h8000);
        sb_i.window_sums(61440, 0);
        load_pair(16'h8000, 16'h0000);
        sb_i.window_sums(0, 32768);
        load_pair(16'h0000, 16'h7fff);
        sb_i.window_sums(32768, 61440);
        sb_i.finish_test();

        $display("Totals: %0d tests passed, %0d tests failed, %0d mismatches, %0d assertion failures",
                 sb_i.tests_passed, sb_i.tests_failed, sb_i.errors, dut_i.chk_i.fail_count);
        if (!timed_out && sb_i.tests_failed == 0 && sb_i.errors == 0 &&
            dut_i.chk_i.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/audio_pkg.sv
design/audio_sample_hold.sv
design/audio_dac_pwm.sv
design/audio_word_select.sv
design/audio_out_top.sv
tests/audio_out_chk.sv
tests/audio_out_scoreboard.sv
tests/audio_out_tb.sv

// ==== Makefile ====
# Verilator build and run of the audio output path testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= audio_out_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
